/* verilog/mrd_pkg.sv */
// shared types of the DFT frame memory
// RTL and testbench refer to these through mrd_pkg:: scoped names
package mrd_pkg;

	// interleaved RAM banks, sample n lives in bank n mod 7
	localparam int NUM_BANKS = 7;
	// factor digits carried in a configuration word
	localparam int NUM_FACTOR_SLOTS = 6;

	typedef logic signed [17:0] sample_t;
	typedef logic [11:0]        frame_idx_t;
	typedef logic [7:0]         bank_addr_t;
	typedef logic [2:0]         bank_idx_t;
	typedef logic [2:0]         factor_t;

	// element 0 is the least significant digit of the input index
	typedef factor_t [NUM_FACTOR_SLOTS-1:0] factors_t;

	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	// frame length and radix factors, 1 marks an unused factor
	typedef struct packed {
		frame_idx_t dftpts;
		factors_t   factors;
	} mrd_cfg_t;

	typedef struct packed {
		logic  valid;
		logic  sop;
		cplx_t data;
	} mrd_in_t;

	typedef struct packed {
		logic  valid;
		logic  sop;
		logic  eop;
		cplx_t data;
	} mrd_out_t;

	// bank ports
	typedef struct packed {
		logic       en;
		bank_addr_t addr;
		cplx_t      data;
	} mrd_wr_t;

	typedef struct packed {
		logic       en;
		bank_addr_t addr;
	} mrd_rd_t;

endpackage

/* verilog/divider_7.sv */
`timescale 1ns/1ps
// splits a frame index into bank word (div 7) and bank number (mod 7)
// purely combinational, multiply-shift estimate plus one correction
module divider_7 (
	input  mrd_pkg::frame_idx_t dividend,
	output mrd_pkg::bank_addr_t quotient,
	output mrd_pkg::bank_idx_t  remainder
);

	// 9362/2^16 is just under 1/7, estimate is q or q-1
	logic [25:0] prod;
	logic [9:0]  q_est;
	logic [11:0] q_x7;
	logic [11:0] r_est;
	logic [11:0] r_fix;

	always_comb
	begin
		prod  = dividend * 14'd9362;
		q_est = prod[25:16];
		q_x7  = ({2'b00, q_est} << 3) - {2'b00, q_est};
		r_est = dividend - q_x7;
		r_fix = r_est - 12'd7;

		// estimate one short, remainder still 7 or more
		if (r_est >= 12'd7)
		begin
			quotient  = q_est[7:0] + 8'd1;
			remainder = r_fix[2:0];
		end
		else
		begin
			quotient  = q_est[7:0];
			remainder = r_est[2:0];
		end
	end

endmodule

/* verilog/mrd_bank_ram.sv */
`timescale 1ns/1ps
// one frame bank, simple dual port
// synchronous write, read data registered when rd.en is high
module mrd_bank_ram #(
	parameter int BANK_DEPTH = 256
) (
	input  logic             clk,
	input  mrd_pkg::mrd_wr_t wr,
	input  mrd_pkg::mrd_rd_t rd,
	output mrd_pkg::cplx_t   rdata
);

	mrd_pkg::cplx_t mem [BANK_DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr.en)
			mem[wr.addr] <= wr.data;
	end

	// output holds until the next enabled read
	always_ff @(posedge clk)
	begin
		if (rd.en)
			rdata <= mem[rd.addr];
	end

endmodule

/* verilog/mrd_digit_rev_addr.sv */
`timescale 1ns/1ps
// mixed-radix digit-reversed index generator, one index per cycle
// factor 0 digit turns slowest, highest used factor fastest
module mrd_digit_rev_addr #(
	parameter int MAX_FACTORS = 6
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  mrd_pkg::factors_t   factors,
	output mrd_pkg::frame_idx_t idx,
	output logic                last
);

	mrd_pkg::factor_t       digit      [MAX_FACTORS];
	mrd_pkg::frame_idx_t    stride     [MAX_FACTORS];
	mrd_pkg::frame_idx_t    stride_nxt [MAX_FACTORS];
	// digit times stride, kept per digit
	mrd_pkg::frame_idx_t    contrib    [MAX_FACTORS];
	logic [MAX_FACTORS-1:0] wrap;
	logic [MAX_FACTORS-1:0] step;

	// stride of digit j is the product of factors below j
	always_comb
	begin
		mrd_pkg::frame_idx_t run;
		run = 12'd1;
		for (int j = 0; j < MAX_FACTORS; j++)
		begin
			stride_nxt[j] = run;
			run = run * mrd_pkg::frame_idx_t'(factors[j]);
		end
	end

	// odometer carry chain, unused factors of 1 always pass the carry
	always_comb
	begin
		logic carry;
		carry = 1'b1;
		for (int j = MAX_FACTORS - 1; j >= 0; j--)
		begin
			wrap[j] = ({1'b0, digit[j]} + 4'd1) >= {1'b0, factors[j]};
			step[j] = carry;
			carry   = carry & wrap[j];
		end
	end

	// every digit at its top value
	assign last = &wrap;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int j = 0; j < MAX_FACTORS; j++)
			begin
				digit[j]   <= '0;
				contrib[j] <= '0;
				stride[j]  <= '0;
			end
		end
		else if (start)
		begin
			for (int j = 0; j < MAX_FACTORS; j++)
			begin
				digit[j]   <= '0;
				contrib[j] <= '0;
				stride[j]  <= stride_nxt[j];
			end
		end
		else
		begin
			for (int j = 0; j < MAX_FACTORS; j++)
			begin
				if (step[j] & wrap[j])
				begin
					digit[j]   <= '0;
					contrib[j] <= '0;
				end
				else if (step[j])
				begin
					digit[j]   <= digit[j] + 1'b1;
					contrib[j] <= contrib[j] + stride[j];
				end
			end
		end
	end

	always_comb
	begin
		idx = '0;
		for (int j = 0; j < MAX_FACTORS; j++)
			idx = idx + contrib[j];
	end

endmodule

/* verilog/mrd_sink.sv */
`timescale 1ns/1ps
// writes input sample n to bank n mod 7 at word n div 7
// two edges after it is presented, then hands the frame on
module mrd_sink #(
	parameter int BANK_DEPTH  = 256,
	parameter int MAX_FACTORS = 6
) (
	input  logic              clk,
	input  logic              rst_n,
	input  mrd_pkg::mrd_in_t  in_data,
	input  mrd_pkg::mrd_cfg_t cfg,
	input  logic              src_busy,
	output mrd_pkg::mrd_wr_t  wr [mrd_pkg::NUM_BANKS],
	output logic              frame_done,
	output mrd_pkg::mrd_cfg_t frame_cfg,
	output logic              sink_busy
);

	localparam mrd_pkg::frame_idx_t IDX_LIMIT =
		mrd_pkg::frame_idx_t'(mrd_pkg::NUM_BANKS * BANK_DEPTH);

	typedef enum logic [1:0] {
		S_IDLE,
		S_FILL,
		S_DRAIN,
		S_DONE
	} sink_state_t;

	sink_state_t         state;
	logic                accept;
	logic                take;
	logic                v1;
	logic                v2;
	mrd_pkg::frame_idx_t idx_r;
	mrd_pkg::cplx_t      d1;
	mrd_pkg::cplx_t      d2;
	mrd_pkg::bank_addr_t q_nxt;
	mrd_pkg::bank_addr_t q_r;
	mrd_pkg::bank_idx_t  r_nxt;
	mrd_pkg::bank_idx_t  r_r;

	// new frame only when both sides are idle
	assign accept = in_data.valid & in_data.sop & (state == S_IDLE) & ~src_busy;
	assign take   = (state == S_FILL) & in_data.valid;

	//----------------------------------------------------------
	// frame control
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state <= S_IDLE;
		else
		begin
			case (state)
			S_IDLE:
				if (accept)
					state <= S_FILL;
			S_FILL:
				if (!in_data.valid)
					state <= S_DRAIN;
			// last sample is in the write stage
			S_DRAIN:
				state <= S_DONE;
			default:
				state <= S_IDLE;
			endcase
		end
	end

	assign frame_done = (state == S_DONE);
	assign sink_busy  = (state != S_IDLE);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			frame_cfg <= '0;
		else if (accept)
		begin
			frame_cfg.dftpts <= cfg.dftpts;
			for (int i = 0; i < mrd_pkg::NUM_FACTOR_SLOTS; i++)
				frame_cfg.factors[i] <= (i < MAX_FACTORS) ? cfg.factors[i] : 3'd1;
		end
	end

	//----------------------------------------------------------
	// write pipeline
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			v1    <= 1'b0;
			v2    <= 1'b0;
			idx_r <= '0;
		end
		else
		begin
			v1 <= accept | take;
			// indices past the bank space are dropped
			v2 <= v1 & (idx_r < IDX_LIMIT);
			if (accept)
				idx_r <= '0;
			else if (take)
				idx_r <= idx_r + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		d1  <= in_data.data;
		d2  <= d1;
		q_r <= q_nxt;
		r_r <= r_nxt;
	end

	divider_7 div_inst (
		.dividend  (idx_r),
		.quotient  (q_nxt),
		.remainder (r_nxt)
	);

	// one-hot bank select
	always_comb
	begin
		for (int b = 0; b < mrd_pkg::NUM_BANKS; b++)
		begin
			wr[b].en   = v2 & (r_r == mrd_pkg::bank_idx_t'(b));
			wr[b].addr = q_r;
			wr[b].data = d2;
		end
	end

endmodule

/* verilog/mrd_source.sv */
`timescale 1ns/1ps
// output side: reads the held frame in digit-reversed order
// sop three cycles after frame_done, then dftpts contiguous samples
module mrd_source #(
	parameter int BANK_DEPTH  = 256,
	parameter int MAX_FACTORS = 6
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              frame_done,
	input  mrd_pkg::mrd_cfg_t frame_cfg,
	input  mrd_pkg::cplx_t    rdata [mrd_pkg::NUM_BANKS],
	output mrd_pkg::mrd_rd_t  rd [mrd_pkg::NUM_BANKS],
	output mrd_pkg::mrd_out_t out_data,
	output logic              src_busy
);

	localparam mrd_pkg::frame_idx_t IDX_LIMIT =
		mrd_pkg::frame_idx_t'(mrd_pkg::NUM_BANKS * BANK_DEPTH);

	logic                reading;
	logic                first_rd;
	logic                rd_ok;
	mrd_pkg::frame_idx_t gen_idx;
	logic                gen_last;
	mrd_pkg::bank_addr_t rd_addr;
	mrd_pkg::bank_idx_t  rd_bank;
	// read in flight
	logic                rd_v_r;
	logic                rd_sop_r;
	logic                rd_eop_r;
	mrd_pkg::bank_idx_t  bank_r;
	// output register
	logic                out_valid;
	logic                out_sop;
	logic                out_eop;
	mrd_pkg::cplx_t      out_dat;

	mrd_digit_rev_addr #(
		.MAX_FACTORS (MAX_FACTORS)
	) addr_gen_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (frame_done),
		.factors (frame_cfg.factors),
		.idx     (gen_idx),
		.last    (gen_last)
	);

	divider_7 div_inst (
		.dividend  (gen_idx),
		.quotient  (rd_addr),
		.remainder (rd_bank)
	);

	assign rd_ok = gen_idx < IDX_LIMIT;

	always_comb
	begin
		for (int b = 0; b < mrd_pkg::NUM_BANKS; b++)
		begin
			rd[b].en   = reading & rd_ok & (rd_bank == mrd_pkg::bank_idx_t'(b));
			rd[b].addr = rd_addr;
		end
	end

	//----------------------------------------------------------
	// read and output control
	//----------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			reading   <= 1'b0;
			first_rd  <= 1'b0;
			src_busy  <= 1'b0;
			rd_v_r    <= 1'b0;
			rd_sop_r  <= 1'b0;
			rd_eop_r  <= 1'b0;
			out_valid <= 1'b0;
			out_sop   <= 1'b0;
			out_eop   <= 1'b0;
		end
		else
		begin
			first_rd <= frame_done;
			if (frame_done)
				reading <= 1'b1;
			else if (gen_last)
				reading <= 1'b0;

			// held until the cycle after eop
			if (frame_done)
				src_busy <= 1'b1;
			else if (out_eop)
				src_busy <= 1'b0;

			rd_v_r    <= reading;
			rd_sop_r  <= first_rd;
			rd_eop_r  <= reading & gen_last;
			out_valid <= rd_v_r;
			out_sop   <= rd_sop_r;
			out_eop   <= rd_eop_r;
		end
	end

	// bank number follows its read, picks the returning word
	always_ff @(posedge clk)
	begin
		bank_r  <= rd_bank;
		out_dat <= rdata[bank_r];
	end

	assign out_data = '{valid: out_valid, sop: out_sop, eop: out_eop, data: out_dat};

endmodule

/* verilog/mrd_mem_top.sv */
`timescale 1ns/1ps
// frame memory of the mixed-radix DFT engine
// sink fills seven banks, source streams the frame out digit-reversed
module mrd_mem_top #(
	parameter int BANK_DEPTH  = 256,
	parameter int MAX_FACTORS = 6
) (
	input  logic              clk,
	input  logic              rst_n,
	input  mrd_pkg::mrd_in_t  in_data,
	input  mrd_pkg::mrd_cfg_t cfg,
	output mrd_pkg::mrd_out_t out_data,
	output logic              busy
);

	mrd_pkg::mrd_wr_t  wr    [mrd_pkg::NUM_BANKS];
	mrd_pkg::mrd_rd_t  rd    [mrd_pkg::NUM_BANKS];
	mrd_pkg::cplx_t    rdata [mrd_pkg::NUM_BANKS];
	logic              frame_done;
	mrd_pkg::mrd_cfg_t frame_cfg;
	logic              sink_busy;
	logic              src_busy;

	//----------------------------------------------------------
	// input side
	//----------------------------------------------------------
	mrd_sink #(
		.BANK_DEPTH  (BANK_DEPTH),
		.MAX_FACTORS (MAX_FACTORS)
	) sink_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_data    (in_data),
		.cfg        (cfg),
		.src_busy   (src_busy),
		.wr         (wr),
		.frame_done (frame_done),
		.frame_cfg  (frame_cfg),
		.sink_busy  (sink_busy)
	);

	//----------------------------------------------------------
	// banks
	//----------------------------------------------------------
	for (genvar i = 0; i < mrd_pkg::NUM_BANKS; i++)
	begin : g_bank
		mrd_bank_ram #(
			.BANK_DEPTH (BANK_DEPTH)
		) ram_inst (
			.clk   (clk),
			.wr    (wr[i]),
			.rd    (rd[i]),
			.rdata (rdata[i])
		);
	end

	//----------------------------------------------------------
	// output side
	//----------------------------------------------------------
	mrd_source #(
		.BANK_DEPTH  (BANK_DEPTH),
		.MAX_FACTORS (MAX_FACTORS)
	) source_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.frame_done (frame_done),
		.frame_cfg  (frame_cfg),
		.rdata      (rdata),
		.rd         (rd),
		.out_data   (out_data),
		.src_busy   (src_busy)
	);

	assign busy = sink_busy | src_busy;

endmodule

/* tests/mrd_mem_tb.sv */
`timescale 1ns/1ps
// streams frames into mrd_mem_top and checks the digit-reversed
// output against a model kept in this testbench
module mrd_mem_tb;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY  = 1;
	localparam int MAX_LEN      = 1792;
	// lengths of every frame offered below including the rejected one
	localparam int FRAME_LEN_SUM   = 5 + 60 + 1600 + 60 + 5 + 60;
	localparam int WATCHDOG_CYCLES = 2 * FRAME_LEN_SUM + 200;

	logic              clk = 1'b0;
	logic              rst_n;
	mrd_pkg::mrd_in_t  in_data;
	mrd_pkg::mrd_cfg_t cfg;
	mrd_pkg::mrd_out_t out_data;
	logic              busy;

	string             test_name = "reset";
	logic [31:0]       rng_state = 32'd30;
	bit                offered = 1'b0;
	bit                eop_prev = 1'b0;
	int                frames_open = 0;
	int                out_pos = 0;
	int                cur_len = 0;
	// model output in the order the DUT must produce it
	mrd_pkg::cplx_t    exp_q [$];
	int                len_q [$];

	mrd_mem_top #(
		.BANK_DEPTH  (256),
		.MAX_FACTORS (6)
	) dut0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.cfg      (cfg),
		.out_data (out_data),
		.busy     (busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//------------------------------------------------------------
	// failure reporting
	//------------------------------------------------------------
	task automatic report_mismatch(input string what, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("** Error: %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
		$display("RESULT: FAIL");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("** Error: %s: %s", test_name, what);
		$display("RESULT: FAIL");
		$fatal(1, "check failed");
	endtask

	//------------------------------------------------------------
	// reference model
	//------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic draw_sample(output mrd_pkg::cplx_t smp);
		rng_state = xorshift32(rng_state);
		smp.re = rng_state[17:0];
		rng_state = xorshift32(rng_state);
		smp.im = rng_state[17:0];
	endtask

	function automatic mrd_pkg::factors_t pack_factors(input int f0, input int f1,
			input int f2, input int f3, input int f4, input int f5);
		mrd_pkg::factors_t f;
		f[0] = mrd_pkg::factor_t'(f0);
		f[1] = mrd_pkg::factor_t'(f1);
		f[2] = mrd_pkg::factor_t'(f2);
		f[3] = mrd_pkg::factor_t'(f3);
		f[4] = mrd_pkg::factor_t'(f4);
		f[5] = mrd_pkg::factor_t'(f5);
		return f;
	endfunction

	function automatic int frame_len(input mrd_pkg::factors_t f);
		int len;
		len = 1;
		for (int j = 0; j < mrd_pkg::NUM_FACTOR_SLOTS; j++)
			len = len * int'(f[j]);
		return len;
	endfunction

	// output position m to input index n
	function automatic int digit_rev_index(input int m, input mrd_pkg::factors_t f);
		int stride [mrd_pkg::NUM_FACTOR_SLOTS];
		int rest;
		int n;
		stride[0] = 1;
		for (int j = 1; j < mrd_pkg::NUM_FACTOR_SLOTS; j++)
			stride[j] = stride[j-1] * int'(f[j-1]);
		rest = m;
		n = 0;
		// m has the highest factor as its least significant digit
		for (int j = mrd_pkg::NUM_FACTOR_SLOTS - 1; j >= 0; j--)
		begin
			n = n + (rest % int'(f[j])) * stride[j];
			rest = rest / int'(f[j]);
		end
		return n;
	endfunction

	//------------------------------------------------------------
	// stimulus driven a small delay after a rising edge
	//------------------------------------------------------------
	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
	endtask

	task automatic wait_idle();
		do
		begin
			@(posedge clk);
			#DRIVE_DELAY;
		end
		while (busy !== 1'b0);
	endtask

	task automatic send_frame(input mrd_pkg::factors_t f, input bit accept_expected);
		int             len;
		mrd_pkg::cplx_t samples [MAX_LEN];
		len = frame_len(f);
		for (int i = 0; i < len; i++)
			draw_sample(samples[i]);
		if (accept_expected)
		begin
			for (int m = 0; m < len; m++)
				exp_q.push_back(samples[digit_rev_index(m, f)]);
			len_q.push_back(len);
		end
		else
			assert (busy === 1'b1)
			else report_failure("busy was low when the frame to be refused was offered");
		offered = 1'b1;
		for (int i = 0; i < len; i++)
		begin
			in_data.valid = 1'b1;
			in_data.sop   = (i == 0);
			in_data.data  = samples[i];
			if (i == 0)
			begin
				cfg.dftpts  = mrd_pkg::frame_idx_t'(len);
				cfg.factors = f;
			end
			@(posedge clk);
			if (i == 0 && accept_expected)
				frames_open++;
			#DRIVE_DELAY;
		end
		// valid low marks the end of the frame
		in_data = '0;
	endtask

	//------------------------------------------------------------
	// output checks on the falling edge
	//------------------------------------------------------------
	task automatic check_output();
		mrd_pkg::cplx_t expected;
		assert (exp_q.size() > 0)
		else report_failure("valid output while no frame was pending");
		expected = exp_q.pop_front();
		if (out_pos == 0)
			cur_len = len_q.pop_front();
		assert (out_data.sop === (out_pos == 0))
		else report_mismatch($sformatf("sop at position %0d", out_pos), out_pos == 0, out_data.sop);
		assert (out_data.eop === (out_pos == cur_len - 1))
		else report_mismatch($sformatf("eop at position %0d", out_pos),
			out_pos == cur_len - 1, out_data.eop);
		assert (out_data.data === expected)
		else report_mismatch($sformatf("data at position %0d", out_pos), expected, out_data.data);
		if (out_pos == cur_len - 1)
		begin
			out_pos = 0;
			frames_open--;
			eop_prev = 1'b1;
		end
		else
			out_pos++;
	endtask

	always @(negedge clk)
	begin
		if (!offered)
			assert ({out_data.valid, out_data.sop, out_data.eop, busy} === 4'b0000)
			else report_mismatch("valid, sop, eop, busy before the first frame", 4'b0000,
				{out_data.valid, out_data.sop, out_data.eop, busy});
		if (frames_open > 0)
			assert (busy === 1'b1)
			else report_failure("busy went low while a frame was held or streaming");
		if (eop_prev)
			assert (busy === 1'b0)
			else report_failure("busy still high in the cycle after eop");
		eop_prev = 1'b0;
		if (out_data.valid === 1'b1)
			check_output();
		else
		begin
			assert (out_pos == 0)
			else report_failure("valid dropped in the middle of a frame");
		end
	end

	// sop and eop only ride on a valid sample
	assert property (@(negedge clk) out_data.valid || !(out_data.sop || out_data.eop))
	else report_failure("sop or eop seen without valid");

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("** Error: %s: run did not finish within %0d cycles", test_name, WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		rst_n   = 1'b0;
		in_data = '0;
		cfg     = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		idle_cycles(5);

		test_name = "single_factor";
		send_frame(pack_factors(5, 1, 1, 1, 1, 1), 1'b1);
		wait_idle();

		test_name = "mixed_radix";
		send_frame(pack_factors(3, 4, 5, 1, 1, 1), 1'b1);
		wait_idle();

		test_name = "large_frame";
		send_frame(pack_factors(4, 4, 4, 5, 5, 1), 1'b1);
		wait_idle();

		// second sop arrives while the first frame is still held
		test_name = "busy_reject";
		send_frame(pack_factors(2, 5, 3, 2, 1, 1), 1'b1);
		idle_cycles(1);
		send_frame(pack_factors(5, 1, 1, 1, 1, 1), 1'b0);
		wait_idle();
		send_frame(pack_factors(5, 3, 4, 1, 1, 1), 1'b1);
		wait_idle();
		idle_cycles(3);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* build.f */
verilog/mrd_pkg.sv
verilog/divider_7.sv
verilog/mrd_bank_ram.sv
verilog/mrd_digit_rev_addr.sv
verilog/mrd_sink.sv
verilog/mrd_source.sv
verilog/mrd_mem_top.sv
tests/mrd_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles the frame memory testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass line.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=mrd_mem_sim

verilator --binary --timing --assert -Wno-fatal \
	--top-module mrd_mem_tb \
	-f build.f \
	-Mdir "${BUILD_DIR}" \
	-o "${SIM_BIN}"
status=$?
if [ ${status} -ne 0 ]; then
	echo "verilator compile failed with status ${status}"
	exit 1
fi

sim_output=$("./${BUILD_DIR}/${SIM_BIN}" 2>&1)
status=$?
echo "${sim_output}"
if [ ${status} -ne 0 ]; then
	echo "simulation exited with status ${status}"
	exit 1
fi

if echo "${sim_output}" | grep -qx "RESULT: PASS"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1
